//--- source/conv2d_cfg.svh
`ifndef CONV2D_CFG_SVH
`define CONV2D_CFG_SVH

// memory interface widths
`define CONV_AWIDTH 32
`define CONV_DWIDTH 32

// kernel side, tied to the one-pixel halo
`define CONV_WT_DIM 3

// read and write data FIFOs, log2 of depth
`define CONV_IN_FIFO_LOGDEPTH 10

// per-row alignment FIFOs
// two padded rows must fit, so fm_dim stays at or below 62
`define CONV_PE_FIFO_LOGDEPTH 7

`endif

//--- source/conv2d_pkg.sv
`include "conv2d_cfg.svh"

package conv2d_pkg;

    // one word on the data bus
    typedef logic [`CONV_DWIDTH-1:0] data_t;

    // byte address toward memory
    typedef logic [`CONV_AWIDTH-1:0] addr_t;

    // burst lengths and image dimensions
    typedef logic [31:0] len_t;

    // controller sequence
    typedef enum logic [2:0] {
        state_idle,
        state_load_wt,
        state_load_fm,
        state_last_write,
        state_store_fm,
        state_wait_resp
    } conv_state_e;

endpackage

//--- source/fifo.sv
`timescale 1ns/1ps

module fifo #(
    parameter int WIDTH = 32,
    parameter int LOGDEPTH = 4
) (
    input  logic             clk,
    input  logic             write_counter_rst,
    input  logic             enq_valid,
    input  logic [WIDTH-1:0] enq_data,
    output logic             enq_ready,
    output logic             deq_valid,
    output logic [WIDTH-1:0] deq_data,
    input  logic             deq_ready
);

    localparam logic [LOGDEPTH:0] DEPTH = 1 << LOGDEPTH;

    logic [WIDTH-1:0] mem [DEPTH];
    logic [LOGDEPTH-1:0] wr_ptr;
    logic [LOGDEPTH-1:0] rd_ptr;
    logic [LOGDEPTH:0] count;
    logic enq_fire;
    logic deq_fire;

    assign enq_ready = (count != DEPTH);
    assign deq_valid = (count != '0);
    // head word shows without a read cycle
    assign deq_data = mem[rd_ptr];

    assign enq_fire = enq_valid & enq_ready;
    assign deq_fire = deq_valid & deq_ready;

    always_ff @(posedge clk) begin
        if (enq_fire) begin
            mem[wr_ptr] <= enq_data;
        end
    end

    always_ff @(posedge clk) begin
        if (write_counter_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (enq_fire) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (deq_fire) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({enq_fire, deq_fire})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- source/conv2d_pe.sv
`timescale 1ns/1ps
`include "conv2d_cfg.svh"

module conv2d_pe #(
    parameter int ROW = 0
) (
    input  logic              clk,
    input  logic              write_counter_rst,
    input  conv2d_pkg::len_t  fm_dim,
    input  conv2d_pkg::data_t weight_data,
    input  logic              weight_valid,
    input  conv2d_pkg::data_t pixel_data,
    input  logic              pixel_valid,
    output conv2d_pkg::data_t psum_data,
    output logic              psum_valid
);

    import conv2d_pkg::*;

    localparam int WT_DIM = `CONV_WT_DIM;
    localparam int CNT_W = $clog2(WT_DIM);
    localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(WT_DIM - 1);
    localparam logic [CNT_W-1:0] MY_ROW = CNT_W'(ROW);

    logic [CNT_W-1:0] wt_col;
    logic [CNT_W-1:0] wt_row;
    data_t weights [WT_DIM];

    data_t hist [WT_DIM-1];
    data_t taps [WT_DIM];
    data_t dot;

    len_t pcol;
    len_t prow;
    logic row_hit;
    logic fire;

    // weights arrive in raster order, keep only this row
    always_ff @(posedge clk) begin
        if (write_counter_rst) begin
            wt_col <= '0;
            wt_row <= '0;
        end else if (weight_valid) begin
            if (wt_col == CNT_MAX) begin
                wt_col <= '0;
                wt_row <= (wt_row == CNT_MAX) ? '0 : wt_row + 1'b1;
            end else begin
                wt_col <= wt_col + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (weight_valid && (wt_row == MY_ROW)) begin
            weights[wt_col] <= weight_data;
        end
    end

    // hist[0] holds the previous pixel
    always_ff @(posedge clk) begin
        if (pixel_valid) begin
            hist[0] <= pixel_data;
            for (int k = 1; k < WT_DIM - 1; k++) begin
                hist[k] <= hist[k-1];
            end
        end
    end

    always_comb begin
        taps[WT_DIM-1] = pixel_data;
        for (int k = 0; k < WT_DIM - 1; k++) begin
            taps[k] = hist[WT_DIM-2-k];
        end
        dot = '0;
        for (int k = 0; k < WT_DIM; k++) begin
            dot = dot + weights[k] * taps[k];
        end
    end

    // padded position of the incoming pixel
    always_ff @(posedge clk) begin
        if (write_counter_rst) begin
            pcol <= '0;
            prow <= '0;
        end else if (pixel_valid) begin
            if (pcol == fm_dim + 1) begin
                pcol <= '0;
                prow <= (prow == fm_dim + 1) ? '0 : prow + 1'b1;
            end else begin
                pcol <= pcol + 1'b1;
            end
        end
    end

    assign row_hit = (prow >= len_t'(ROW)) && (prow < len_t'(ROW) + fm_dim);
    assign fire = pixel_valid && (pcol >= len_t'(WT_DIM - 1)) && row_hit;

    always_ff @(posedge clk) begin
        if (write_counter_rst) begin
            psum_valid <= 1'b0;
        end else begin
            psum_valid <= fire;
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            psum_data <= dot;
        end
    end

endmodule

//--- source/conv2d_pe_array.sv
`timescale 1ns/1ps
`include "conv2d_cfg.svh"

module conv2d_pe_array (
    input  logic              clk,
    input  logic              write_counter_rst,
    input  conv2d_pkg::len_t  fm_dim,
    input  conv2d_pkg::data_t weight_data,
    input  logic              weight_valid,
    input  conv2d_pkg::data_t pixel_data,
    input  logic              pixel_valid,
    output conv2d_pkg::data_t sum_data,
    output logic              sum_valid,
    input  logic              sum_ready,
    output logic              pe_fifo_full
);

    import conv2d_pkg::*;

    localparam int WT_DIM = `CONV_WT_DIM;

    data_t psum_data [WT_DIM];
    logic [WT_DIM-1:0] psum_valid;
    logic [WT_DIM-1:0] enq_ready;
    data_t head_data [WT_DIM];
    logic [WT_DIM-1:0] head_valid;
    logic pop;

    // row i of the kernel, row 0 runs two padded rows ahead of the last
    for (genvar i = 0; i < WT_DIM; i++) begin : g_row
        conv2d_pe #(
            .ROW(i)
        ) pe (
            .clk(clk),
            .write_counter_rst(write_counter_rst),
            .fm_dim(fm_dim),
            .weight_data(weight_data),
            .weight_valid(weight_valid),
            .pixel_data(pixel_data),
            .pixel_valid(pixel_valid),
            .psum_data(psum_data[i]),
            .psum_valid(psum_valid[i])
        );

        fifo #(
            .WIDTH(`CONV_DWIDTH),
            .LOGDEPTH(`CONV_PE_FIFO_LOGDEPTH)
        ) align_fifo (
            .clk(clk),
            .write_counter_rst(write_counter_rst),
            .enq_valid(psum_valid[i]),
            .enq_data(psum_data[i]),
            .enq_ready(enq_ready[i]),
            .deq_valid(head_valid[i]),
            .deq_data(head_data[i]),
            .deq_ready(pop)
        );
    end

    assign sum_valid = &head_valid;
    assign pop = sum_valid & sum_ready;

    always_comb begin
        sum_data = '0;
        for (int k = 0; k < WT_DIM; k++) begin
            sum_data = sum_data + head_data[k];
        end
    end

    // one psum can still be in flight behind a pixel,
    // so hold pixels while a psum lands without a pop
    assign pe_fifo_full = !(&enq_ready) | ((|psum_valid) & ~pop);

    a_no_psum_drop: assert property (@(posedge clk) disable iff (write_counter_rst)
        (psum_valid & ~enq_ready) == '0);

endmodule

//--- source/conv2d_opt_compute.sv
`timescale 1ns/1ps
`include "conv2d_cfg.svh"

module conv2d_opt_compute (
    input  logic              clk,
    input  logic              write_counter_rst,
    input  logic              start,
    output logic              idle,
    input  conv2d_pkg::len_t  fm_dim,
    input  conv2d_pkg::addr_t wt_offset,
    input  conv2d_pkg::addr_t ifm_offset,
    input  conv2d_pkg::addr_t ofm_offset,
    // read request
    output conv2d_pkg::addr_t req_read_addr,
    output conv2d_pkg::len_t  req_read_len,
    output logic              req_read_addr_valid,
    input  logic              req_read_addr_ready,
    input  conv2d_pkg::data_t rdata,
    input  logic              rdata_valid,
    output logic              rdata_ready,
    // write request
    output conv2d_pkg::addr_t req_write_addr,
    output conv2d_pkg::len_t  req_write_len,
    output logic              req_write_addr_valid,
    input  logic              req_write_addr_ready,
    output conv2d_pkg::data_t req_write_data,
    output logic              req_write_data_valid,
    input  logic              req_write_data_ready,
    // write response, status value not checked
    input  logic              resp_write_status,
    input  logic              resp_write_status_valid,
    output logic              resp_write_status_ready
);

    import conv2d_pkg::*;

    localparam int WT_DIM = `CONV_WT_DIM;
    localparam int CNT_W = $clog2(WT_DIM);
    localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(WT_DIM - 1);
    localparam len_t WT_LEN = len_t'(WT_DIM * WT_DIM);

    conv_state_e state_q;
    conv_state_e state_d;

    data_t in_deq_data;
    logic in_deq_valid;
    logic in_deq_ready;
    logic in_fire;

    logic [CNT_W-1:0] m_cnt;
    logic [CNT_W-1:0] n_cnt;
    logic last_wt;

    len_t x_cnt;
    len_t y_cnt;
    len_t fm_sq;
    logic halo;
    logic pix_go;
    logic last_pix;
    data_t pixel_data;

    logic pe_fifo_full;
    data_t sum_data;
    logic sum_valid;
    logic sum_ready;
    logic sum_state;
    logic sum_fire;
    logic out_enq_valid;
    logic out_enq_ready;

    len_t write_cnt;
    logic last_sum;

    fifo #(
        .WIDTH(`CONV_DWIDTH),
        .LOGDEPTH(`CONV_IN_FIFO_LOGDEPTH)
    ) data_in_fifo (
        .clk(clk),
        .write_counter_rst(write_counter_rst),
        .enq_valid(rdata_valid),
        .enq_data(rdata),
        .enq_ready(rdata_ready),
        .deq_valid(in_deq_valid),
        .deq_data(in_deq_data),
        .deq_ready(in_deq_ready)
    );

    fifo #(
        .WIDTH(`CONV_DWIDTH),
        .LOGDEPTH(`CONV_IN_FIFO_LOGDEPTH)
    ) data_out_fifo (
        .clk(clk),
        .write_counter_rst(write_counter_rst),
        .enq_valid(out_enq_valid),
        .enq_data(sum_data),
        .enq_ready(out_enq_ready),
        .deq_valid(req_write_data_valid),
        .deq_data(req_write_data),
        .deq_ready(req_write_data_ready)
    );

    conv2d_pe_array pe_array (
        .clk(clk),
        .write_counter_rst(write_counter_rst),
        .fm_dim(fm_dim),
        .weight_data(in_deq_data),
        .weight_valid(in_fire && (state_q == state_load_wt)),
        .pixel_data(pixel_data),
        .pixel_valid(pix_go),
        .sum_data(sum_data),
        .sum_valid(sum_valid),
        .sum_ready(sum_ready),
        .pe_fifo_full(pe_fifo_full)
    );

    assign fm_sq = fm_dim * fm_dim;
    assign idle = (state_q == state_idle);

    always_comb begin
        state_d = state_q;
        case (state_q)
            state_idle: begin
                if (start) begin
                    state_d = state_load_wt;
                end
            end
            state_load_wt: begin
                if (last_wt) begin
                    state_d = state_load_fm;
                end
            end
            state_load_fm: begin
                if (last_pix) begin
                    state_d = state_last_write;
                end
            end
            state_last_write: begin
                if (last_sum) begin
                    state_d = state_store_fm;
                end
            end
            state_store_fm: begin
                if (req_write_addr_valid && req_write_addr_ready) begin
                    state_d = state_wait_resp;
                end
            end
            state_wait_resp: begin
                if (resp_write_status_valid && resp_write_status_ready) begin
                    state_d = state_idle;
                end
            end
            default: state_d = state_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (write_counter_rst) begin
            state_q <= state_idle;
        end else begin
            state_q <= state_d;
        end
    end

    // weights take every word, halo positions skip the FIFO
    assign in_deq_ready = (state_q == state_load_wt)
                        | ((state_q == state_load_fm) & ~halo & ~pe_fifo_full);
    assign in_fire = in_deq_valid & in_deq_ready;
    assign last_wt = (state_q == state_load_wt) & in_fire & (m_cnt == CNT_MAX) & (n_cnt == CNT_MAX);

    always_ff @(posedge clk) begin
        if (write_counter_rst) begin
            m_cnt <= '0;
            n_cnt <= '0;
        end else if ((state_q == state_load_wt) && in_fire) begin
            if (n_cnt == CNT_MAX) begin
                n_cnt <= '0;
                m_cnt <= (m_cnt == CNT_MAX) ? '0 : m_cnt + 1'b1;
            end else begin
                n_cnt <= n_cnt + 1'b1;
            end
        end
    end

    assign halo = (x_cnt == '0) | (y_cnt == '0) | (x_cnt == fm_dim + 1) | (y_cnt == fm_dim + 1);
    assign pix_go = (state_q == state_load_fm) & ~pe_fifo_full & (halo | in_deq_valid);
    assign last_pix = pix_go & (x_cnt == fm_dim + 1) & (y_cnt == fm_dim + 1);
    assign pixel_data = halo ? '0 : in_deq_data;

    always_ff @(posedge clk) begin
        if (write_counter_rst) begin
            x_cnt <= '0;
            y_cnt <= '0;
        end else if (pix_go) begin
            if (x_cnt == fm_dim + 1) begin
                x_cnt <= '0;
                y_cnt <= (y_cnt == fm_dim + 1) ? '0 : y_cnt + 1'b1;
            end else begin
                x_cnt <= x_cnt + 1'b1;
            end
        end
    end

    assign sum_state = (state_q == state_load_fm) | (state_q == state_last_write);
    assign sum_ready = out_enq_ready & sum_state;
    assign out_enq_valid = sum_valid & sum_state;
    assign sum_fire = sum_valid & sum_ready;
    assign last_sum = sum_fire & (write_cnt == fm_sq - 1);

    always_ff @(posedge clk) begin
        if (write_counter_rst) begin
            write_cnt <= '0;
        end else if (last_sum) begin
            write_cnt <= '0;
        end else if (sum_fire) begin
            write_cnt <= write_cnt + 1'b1;
        end
    end

    // read bursts, weights first then the map
    assign req_read_addr = (state_q == state_load_wt) ? wt_offset
                         : (state_q == state_load_fm) ? ifm_offset : '0;
    assign req_read_len = (state_q == state_load_wt) ? WT_LEN
                        : (state_q == state_load_fm) ? fm_sq : '0;

    always_ff @(posedge clk) begin
        if (write_counter_rst) begin
            req_read_addr_valid <= 1'b0;
        end else if (((state_q == state_idle) && start) || last_wt) begin
            req_read_addr_valid <= 1'b1;
        end else if (req_read_addr_valid && req_read_addr_ready) begin
            req_read_addr_valid <= 1'b0;
        end
    end

    assign req_write_addr = ofm_offset;
    assign req_write_len = fm_sq;

    always_ff @(posedge clk) begin
        if (write_counter_rst) begin
            req_write_addr_valid <= 1'b0;
        end else if (last_sum) begin
            req_write_addr_valid <= 1'b1;
        end else if (req_write_addr_valid && req_write_addr_ready) begin
            req_write_addr_valid <= 1'b0;
        end
    end

    // take the response only once all write data has left
    assign resp_write_status_ready = (state_q == state_wait_resp) & ~req_write_data_valid;

    a_read_len_nonzero: assert property (@(posedge clk) disable iff (write_counter_rst)
        req_read_addr_valid |-> (req_read_len != '0));

endmodule

//--- dv/conv2d_tb.sv
`timescale 1ns/1ps

module conv2d_tb;

    import conv2d_pkg::*;

    localparam int MEM_WORDS = 4096;
    localparam int PAT_WORDS = 256;
    localparam int WT_WORDS = 9;
    localparam int RESP_LIMIT = 20000;
    localparam int IDLE_LIMIT = 16;
    localparam int MAX_CASES = 8;

    logic clk;
    logic write_counter_rst;
    logic start;
    logic idle;
    len_t fm_dim;
    addr_t wt_offset;
    addr_t ifm_offset;
    addr_t ofm_offset;
    addr_t req_read_addr;
    len_t req_read_len;
    logic req_read_addr_valid;
    logic req_read_addr_ready;
    data_t rdata;
    logic rdata_valid;
    logic rdata_ready;
    addr_t req_write_addr;
    len_t req_write_len;
    logic req_write_addr_valid;
    logic req_write_addr_ready;
    data_t req_write_data;
    logic req_write_data_valid;
    logic req_write_data_ready;
    logic resp_write_status;
    logic resp_write_status_valid;
    logic resp_write_status_ready;

    data_t mem_model [MEM_WORDS];
    logic [31:0] pat [PAT_WORDS];
    data_t exp_q [$];
    integer seed = 78;
    int check_errors;
    int proto_errors;
    int timeout_errors;

    // current case and memory model state
    len_t cur_fm;
    addr_t cur_wt_offset;
    addr_t cur_ifm_offset;
    addr_t cur_ofm_offset;
    addr_t rd_addr;
    len_t rd_left;
    len_t rd_idx;
    len_t rd_total;
    int rd_req_cnt;
    logic rd_fire;
    logic resp_fire;
    len_t wr_cnt;
    logic wr_addr_seen;
    logic resp_sent;
    logic resp_done;
    logic run_active;

    conv2d_opt_compute u_dut (
        .clk(clk),
        .write_counter_rst(write_counter_rst),
        .start(start),
        .idle(idle),
        .fm_dim(fm_dim),
        .wt_offset(wt_offset),
        .ifm_offset(ifm_offset),
        .ofm_offset(ofm_offset),
        .req_read_addr(req_read_addr),
        .req_read_len(req_read_len),
        .req_read_addr_valid(req_read_addr_valid),
        .req_read_addr_ready(req_read_addr_ready),
        .rdata(rdata),
        .rdata_valid(rdata_valid),
        .rdata_ready(rdata_ready),
        .req_write_addr(req_write_addr),
        .req_write_len(req_write_len),
        .req_write_addr_valid(req_write_addr_valid),
        .req_write_addr_ready(req_write_addr_ready),
        .req_write_data(req_write_data),
        .req_write_data_valid(req_write_data_valid),
        .req_write_data_ready(req_write_data_ready),
        .resp_write_status(resp_write_status),
        .resp_write_status_valid(resp_write_status_valid),
        .resp_write_status_ready(resp_write_status_ready)
    );

    always #4 clk = ~clk;

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            check_errors++;
            $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_len(input string name, input len_t got, input len_t exp);
        if (got !== exp) begin
            check_errors++;
            $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_data(input string name, input data_t got, input data_t exp);
        if (got !== exp) begin
            check_errors++;
            $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            check_errors++;
            $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
        end
    endtask

    // three of four cycles pass
    function automatic logic random_go();
        random_go = (($random(seed) & 3) != 0);
    endfunction

    function automatic int mem_index(input addr_t a);
        mem_index = int'(a % MEM_WORDS);
    endfunction

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    // handshakes as seen at the rising edge
    task automatic sample_channels();
        data_t exp_word;
        rd_fire = rdata_valid && rdata_ready;
        resp_fire = resp_write_status_valid && resp_write_status_ready;
        if (rd_fire) begin
            rd_idx++;
            rd_left--;
            rd_total++;
        end
        if (req_read_addr_valid && req_read_addr_ready) begin
            if (rd_req_cnt == 0) begin
                check_addr("req_read_addr", req_read_addr, cur_wt_offset);
                check_len("req_read_len", req_read_len, len_t'(WT_WORDS));
            end else if (rd_req_cnt == 1) begin
                if (rd_total != len_t'(WT_WORDS)) begin
                    proto_errors++;
                    $display("map read requested after only %0d weights", rd_total);
                end
                check_addr("req_read_addr", req_read_addr, cur_ifm_offset);
                check_len("req_read_len", req_read_len, cur_fm * cur_fm);
            end else begin
                proto_errors++;
                $display("more than two read requests in one run");
            end
            rd_addr = req_read_addr;
            rd_left = req_read_len;
            rd_idx = '0;
            rd_req_cnt++;
        end
        if (req_write_addr_valid && req_write_addr_ready) begin
            if (wr_addr_seen) begin
                proto_errors++;
                $display("second write request in one run");
            end
            check_addr("req_write_addr", req_write_addr, cur_ofm_offset);
            check_len("req_write_len", req_write_len, cur_fm * cur_fm);
            wr_addr_seen = 1'b1;
        end
        if (req_write_data_valid && req_write_data_ready) begin
            if (exp_q.size() == 0) begin
                proto_errors++;
                $display("write data word %0d came after all expected words", wr_cnt);
            end else begin
                exp_word = exp_q.pop_front();
                check_data($sformatf("req_write_data[%0d]", wr_cnt), req_write_data, exp_word);
            end
            wr_cnt++;
        end
        if (resp_write_status_ready && !wr_addr_seen) begin
            proto_errors++;
            $display("write response taken before the write request");
        end
        if (resp_fire) begin
            resp_done = 1'b1;
            run_active = 1'b0;
        end else if (run_active && idle) begin
            check_bit("idle", idle, 1'b0);
            run_active = 1'b0;
        end
    endtask

    // memory side outputs, valids hold until taken
    task automatic drive_channels();
        req_read_addr_ready = random_go();
        req_write_addr_ready = random_go();
        req_write_data_ready = random_go();
        if (!rdata_valid || rd_fire) begin
            if (rd_left != '0 && random_go()) begin
                rdata_valid = 1'b1;
                rdata = mem_model[mem_index(rd_addr + rd_idx)];
            end else begin
                rdata_valid = 1'b0;
            end
        end
        if (!resp_write_status_valid || resp_fire) begin
            if (!resp_sent && wr_addr_seen && wr_cnt == cur_fm * cur_fm && random_go()) begin
                resp_write_status_valid = 1'b1;
                resp_sent = 1'b1;
            end else begin
                resp_write_status_valid = 1'b0;
            end
        end
    endtask

    always @(posedge clk) begin
        if (!write_counter_rst) begin
            sample_channels();
        end
        #1;
        drive_channels();
    end

    task automatic clear_model();
        rd_addr = '0;
        rd_left = '0;
        rd_idx = '0;
        rd_total = '0;
        rd_req_cnt = 0;
        wr_cnt = '0;
        wr_addr_seen = 1'b0;
        resp_sent = 1'b0;
        resp_done = 1'b0;
        run_active = 1'b0;
    endtask

    task automatic run_case(input int base, input int case_idx, output int next);
        int n;
        int npix;
        n = 0;
        cur_fm = pat[base];
        cur_wt_offset = pat[base + 1];
        cur_ifm_offset = pat[base + 2];
        cur_ofm_offset = pat[base + 3];
        npix = int'(cur_fm * cur_fm);
        next = base + 4 + WT_WORDS + 2 * npix;
        if (cur_fm > 62 || next > PAT_WORDS) begin
            proto_errors++;
            $display("case %0d has a map size the engine cannot take", case_idx);
            next = PAT_WORDS;
            return;
        end
        exp_q.delete();
        for (int k = 0; k < WT_WORDS; k++) begin
            mem_model[mem_index(cur_wt_offset + k)] = pat[base + 4 + k];
        end
        for (int k = 0; k < npix; k++) begin
            mem_model[mem_index(cur_ifm_offset + k)] = pat[base + 4 + WT_WORDS + k];
            exp_q.push_back(pat[base + 4 + WT_WORDS + npix + k]);
        end
        clear_model();
        fm_dim = cur_fm;
        wt_offset = cur_wt_offset;
        ifm_offset = cur_ifm_offset;
        ofm_offset = cur_ofm_offset;
        check_bit("idle", idle, 1'b1);
        start = 1'b1;
        step();
        start = 1'b0;
        run_active = 1'b1;
        while (!resp_done && n < RESP_LIMIT) begin
            step();
            n++;
        end
        if (!resp_done) begin
            timeout_errors++;
            $display("timeout: case %0d got no write response in %0d cycles", case_idx, n);
            return;
        end
        n = 0;
        while (!idle && n < IDLE_LIMIT) begin
            step();
            n++;
        end
        if (!idle) begin
            timeout_errors++;
            $display("timeout: case %0d never returned to idle", case_idx);
            return;
        end
        check_len("write word count", wr_cnt, len_t'(npix));
        check_len("read request count", len_t'(rd_req_cnt), len_t'(2));
        $display("case %0d done, fm_dim %0d, %0d words written", case_idx, cur_fm, wr_cnt);
    endtask

    initial begin
        int base;
        int next;
        int case_idx;
        clk = 1'b0;
        write_counter_rst = 1'b1;
        start = 1'b0;
        fm_dim = '0;
        wt_offset = '0;
        ifm_offset = '0;
        ofm_offset = '0;
        req_read_addr_ready = 1'b0;
        rdata = '0;
        rdata_valid = 1'b0;
        req_write_addr_ready = 1'b0;
        req_write_data_ready = 1'b0;
        resp_write_status = 1'b0;
        resp_write_status_valid = 1'b0;
        check_errors = 0;
        proto_errors = 0;
        timeout_errors = 0;
        rd_fire = 1'b0;
        resp_fire = 1'b0;
        cur_fm = '0;
        cur_wt_offset = '0;
        cur_ifm_offset = '0;
        cur_ofm_offset = '0;
        clear_model();
        for (int a = 0; a < MEM_WORDS; a++) begin
            mem_model[a] = 32'hbad00000 | a;
        end
        for (int a = 0; a < PAT_WORDS; a++) begin
            pat[a] = '0;
        end
        $readmemh("dv/conv2d_patterns.hex", pat);

        repeat (3) @(posedge clk);
        #1;
        write_counter_rst = 1'b0;
        step();
        check_bit("idle", idle, 1'b1);
        check_bit("req_read_addr_valid", req_read_addr_valid, 1'b0);
        check_bit("req_write_addr_valid", req_write_addr_valid, 1'b0);
        check_bit("req_write_data_valid", req_write_data_valid, 1'b0);
        check_bit("resp_write_status_ready", resp_write_status_ready, 1'b0);

        base = 0;
        case_idx = 0;
        while (base < PAT_WORDS && pat[base] != '0 && timeout_errors == 0
               && case_idx < MAX_CASES) begin
            run_case(base, case_idx, next);
            base = next;
            case_idx++;
        end
        if (case_idx < 2) begin
            proto_errors++;
            $display("only %0d test cases were found in the pattern file", case_idx);
        end

        $display("errors: %0d check, %0d protocol, %0d timeout",
                 check_errors, proto_errors, timeout_errors);
        if (check_errors == 0 && proto_errors == 0 && timeout_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- conv2d_opt_compute.f
+incdir+source
source/conv2d_pkg.sv
source/fifo.sv
source/conv2d_pe.sv
source/conv2d_pe_array.sv
source/conv2d_opt_compute.sv
dv/conv2d_tb.sv

//--- dv/conv2d_patterns.hex
// per case: fm_dim wt_offset ifm_offset ofm_offset, 9 weights,
// fm_dim^2 pixels, fm_dim^2 expected outputs, raster order; fm_dim of 0 ends
// case 0, 3x3 map
00000003 00000100 00000200 00000800
00000001 00000002 00000003 00000004 00000005 00000006 00000007 00000008 00000009
00000001 00000002 00000003
00000004 00000005 00000006
00000007 00000008 00000009
0000005e 0000009a 0000006a
000000ba 0000011d 000000ba
0000006a 0000009a 0000005e
// case 1, 4x4 map, negative weight wraps
00000004 00000340 00000400 00000a00
00000000 00000001 00000000 00000002 00000000 00000000 00000000 00000000 ffffffff
00000010 00000020 00000030 00000040
00000050 00000060 00000070 00000080
00000090 000000a0 000000b0 000000c0
000000d0 000000e0 000000f0 00000100
ffffffa0 ffffffb0 ffffffc0 00000060
ffffff70 00000010 00000030 00000120
ffffff70 00000090 000000b0 000001e0
00000090 00000240 00000270 000002a0
// end of list
00000000
